// ==== hpet_config.svh ====
// Timer count, register address width and timer block placement macros
`ifndef HPET_CONFIG_SVH
`define HPET_CONFIG_SVH

// ======================================================================
// Timer count
// ======================================================================

// Number of comparators, legal range 1 to 8
`define HPET_NUM_TIMERS 3

// ======================================================================
// Register port addressing
// ======================================================================

// Word address width of the register port
`define HPET_ADDR_W 8

// First word of timer 0's register block
`define HPET_TMR_BASE 8

// Words between consecutive timer blocks
`define HPET_TMR_STRIDE 4

`endif

// ==== hpet_pkg.sv ====
// Register offset enums and packed structs for timer config and comparator writes
`include "hpet_config.svh"

package hpet_pkg;

    // ======================================================================
    // Register offsets
    // ======================================================================

    // Global registers at the bottom of the map
    typedef enum logic [1:0] {
        GEN_CONFIG = 2'd0,
        INT_STATUS = 2'd1,
        COUNTER_LO = 2'd2,
        COUNTER_HI = 2'd3
    } hpet_reg_e;

    // Offsets inside one timer block
    // Word 3 of a block is reserved
    typedef enum logic [1:0] {
        TMR_CONFIG  = 2'd0,
        TMR_COMP_LO = 2'd1,
        TMR_COMP_HI = 2'd2
    } hpet_tmr_reg_e;

    // ======================================================================
    // Per-timer configuration
    // ======================================================================

    // Bit 0 enable .. bit 3 full_width of TMR_CONFIG
    // First member lands in the MSB
    typedef struct packed {
        logic full_width;  // 64-bit compare when set, low 32 bits otherwise
        logic periodic;    // Advance comparator by period on fire
        logic int_enable;  // Lets fire drive timer_irq
        logic enable;      // Gates the match
    } hpet_timer_cfg_t;

    // Comparator write bundle from register file to core
    typedef struct packed {
        logic [`HPET_NUM_TIMERS-1:0] mask;  // One strobe per timer
        logic                        high;  // Upper half selected
        logic [31:0]                 data;
    } hpet_comp_wr_t;

endpackage

// ==== hpet_comparator.sv ====
// Single timer comparator: compare/period registers, match, fire edge, periodic advance
`timescale 1ns/10ps

module hpet_comparator (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      hpet_enable,
    input  hpet_pkg::hpet_timer_cfg_t cfg,

    // Half write from register file
    input  logic                      comp_write,
    input  logic                      comp_high,
    input  logic [31:0]               comp_data,

    // Main counter value
    input  logic [63:0]               counter,

    output logic                      fire,
    output logic [63:0]               comparator
);

    logic [63:0] period;
    logic        match;
    logic        match_q;

    // ======================================================================
    // Comparator and period
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            comparator <= '0;
            period     <= '0;
        end else if (comp_write) begin
            // Same half goes to both, so period tracks last programmed value
            if (comp_high) begin
                comparator[63:32] <= comp_data;
                period[63:32]     <= comp_data;
            end else begin
                comparator[31:0] <= comp_data;
                period[31:0]     <= comp_data;
            end
        end else if (fire && cfg.periodic) begin
            // Next deadline one period on
            comparator <= comparator + period;
        end
    end

    // ======================================================================
    // Match and edge detect
    // ======================================================================

    always_comb begin
        match = 1'b0;
        if (cfg.enable && hpet_enable) begin
            if (cfg.full_width) begin
                match = (counter >= comparator);
            end else begin
                // 32-bit mode ignores both upper halves
                match = (counter[31:0] >= comparator[31:0]);
            end
        end
    end

    // Previous match for rising edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_q <= 1'b0;
        end else begin
            match_q <= match;
        end
    end

    // One cycle pulse per low-to-high match transition
    // One-shot holds match high, so no repeat
    assign fire = match && !match_q;

endmodule

// ==== hpet_regs.sv ====
// Register file: address decode, config registers, write strobes and read mux
`timescale 1ns/10ps
`include "hpet_config.svh"

module hpet_regs (
    input  logic                             clk,
    input  logic                             rst_n,

    // Register port
    input  logic                             reg_wr,
    input  logic [`HPET_ADDR_W-1:0]          reg_addr,
    input  logic [31:0]                      reg_wdata,
    output logic [31:0]                      reg_rdata,

    // Readback from core
    input  logic [63:0]                      counter_rdata,
    input  logic [63:0]                      comp_rdata [`HPET_NUM_TIMERS],
    input  logic [`HPET_NUM_TIMERS-1:0]      int_status,

    // Control towards core
    output logic                             hpet_enable,
    output hpet_pkg::hpet_timer_cfg_t        timer_cfg [`HPET_NUM_TIMERS],
    output logic                             counter_write,
    output logic [63:0]                      counter_wdata,
    output hpet_pkg::hpet_comp_wr_t          comp_wr,
    output logic [`HPET_NUM_TIMERS-1:0]      int_clear
);

    import hpet_pkg::*;

    localparam int AW = `HPET_ADDR_W;
    localparam int N  = `HPET_NUM_TIMERS;
    localparam int CW = $bits(hpet_timer_cfg_t);

    localparam logic [AW-1:0] TMR_BASE   = AW'(`HPET_TMR_BASE);
    localparam logic [AW-1:0] TMR_STRIDE = AW'(`HPET_TMR_STRIDE);

    // ======================================================================
    // Address decode
    // ======================================================================

    logic          glb_sel;
    hpet_reg_e     glb_off;
    logic [AW-1:0] tmr_rel;
    logic [AW-1:0] tmr_idx;
    logic [AW-1:0] tmr_word;
    logic          tmr_sel;
    hpet_tmr_reg_e tmr_off;
    logic [N-1:0]  tmr_hit;

    // Globals occupy words 0 to 3
    assign glb_sel = (reg_addr[AW-1:2] == '0);
    assign glb_off = hpet_reg_e'(reg_addr[1:0]);

    // Split timer area into block index and word in block
    assign tmr_rel  = reg_addr - TMR_BASE;
    assign tmr_idx  = tmr_rel / TMR_STRIDE;
    assign tmr_word = tmr_rel % TMR_STRIDE;
    // Words past the fourth of a wide block stay unmapped
    assign tmr_sel  = (reg_addr >= TMR_BASE) && (tmr_word[AW-1:2] == '0);
    assign tmr_off  = hpet_tmr_reg_e'(tmr_word[1:0]);

    // One-hot block select, zero above the last timer
    always_comb begin
        for (int i = 0; i < N; i++) begin
            tmr_hit[i] = tmr_sel && (tmr_idx == AW'(i));
        end
    end

    // ======================================================================
    // Configuration registers
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hpet_enable <= 1'b0;
            for (int i = 0; i < N; i++) begin
                timer_cfg[i] <= '0;
            end
        end else if (reg_wr) begin
            // Only bit 0 of GEN_CONFIG is implemented
            if (glb_sel && (glb_off == GEN_CONFIG)) begin
                hpet_enable <= reg_wdata[0];
            end
            for (int i = 0; i < N; i++) begin
                if (tmr_hit[i] && (tmr_off == TMR_CONFIG)) begin
                    timer_cfg[i] <= hpet_timer_cfg_t'(reg_wdata[CW-1:0]);
                end
            end
        end
    end

    // ======================================================================
    // Strobes to core
    // ======================================================================

    // Counter write, new half merged with live counter
    assign counter_write = reg_wr && glb_sel &&
                           ((glb_off == COUNTER_LO) || (glb_off == COUNTER_HI));
    assign counter_wdata = (glb_off == COUNTER_HI) ? {reg_wdata, counter_rdata[31:0]}
                                                   : {counter_rdata[63:32], reg_wdata};

    // Comparator half write, shared data and half select
    always_comb begin
        for (int i = 0; i < N; i++) begin
            comp_wr.mask[i] = reg_wr && tmr_hit[i] &&
                              ((tmr_off == TMR_COMP_LO) || (tmr_off == TMR_COMP_HI));
        end
        comp_wr.high = (tmr_off == TMR_COMP_HI);
        comp_wr.data = reg_wdata;
    end

    // Write-one-to-clear on INT_STATUS
    assign int_clear = (reg_wr && glb_sel && (glb_off == INT_STATUS)) ? reg_wdata[N-1:0] : '0;

    // ======================================================================
    // Read mux
    // ======================================================================

    always_comb begin
        reg_rdata = '0;
        if (glb_sel) begin
            case (glb_off)
                GEN_CONFIG: reg_rdata[0]     = hpet_enable;
                INT_STATUS: reg_rdata[N-1:0] = int_status;
                COUNTER_LO: reg_rdata        = counter_rdata[31:0];
                COUNTER_HI: reg_rdata        = counter_rdata[63:32];
                default:    reg_rdata        = '0;
            endcase
        end
        for (int i = 0; i < N; i++) begin
            if (tmr_hit[i]) begin
                case (tmr_off)
                    TMR_CONFIG:  reg_rdata[CW-1:0] = timer_cfg[i];
                    TMR_COMP_LO: reg_rdata         = comp_rdata[i][31:0];
                    TMR_COMP_HI: reg_rdata         = comp_rdata[i][63:32];
                    // Reserved word reads zero
                    default:     reg_rdata         = '0;
                endcase
            end
        end
    end

endmodule

// ==== hpet_core.sv ====
// Timer core: 64-bit main counter, comparator instances, sticky status and irq
`timescale 1ns/10ps
`include "hpet_config.svh"

module hpet_core (
    input  logic                             clk,
    input  logic                             rst_n,

    // Control from register file
    input  logic                             hpet_enable,
    input  hpet_pkg::hpet_timer_cfg_t        timer_cfg [`HPET_NUM_TIMERS],
    input  logic                             counter_write,
    input  logic [63:0]                      counter_wdata,
    input  hpet_pkg::hpet_comp_wr_t          comp_wr,
    input  logic [`HPET_NUM_TIMERS-1:0]      int_clear,

    // Readback and interrupts
    output logic [63:0]                      counter_rdata,
    output logic [63:0]                      comp_rdata [`HPET_NUM_TIMERS],
    output logic [`HPET_NUM_TIMERS-1:0]      int_status,
    output logic [`HPET_NUM_TIMERS-1:0]      timer_irq
);

    localparam int N = `HPET_NUM_TIMERS;

    logic [63:0]  main_counter;
    logic [N-1:0] fire;

    // ======================================================================
    // Main counter
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_counter <= '0;
        end else if (counter_write) begin
            // Software load beats increment
            main_counter <= counter_wdata;
        end else if (hpet_enable) begin
            main_counter <= main_counter + 64'd1;
        end
    end

    assign counter_rdata = main_counter;

    // ======================================================================
    // Comparators
    // ======================================================================

    for (genvar i = 0; i < N; i++) begin : gen_tmr
        hpet_comparator cmp_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .hpet_enable (hpet_enable),
            .cfg         (timer_cfg[i]),
            .comp_write  (comp_wr.mask[i]),
            .comp_high   (comp_wr.high),
            .comp_data   (comp_wr.data),
            .counter     (main_counter),
            .fire        (fire[i]),
            .comparator  (comp_rdata[i])
        );
    end

    // ======================================================================
    // Interrupt status and lines
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_status <= '0;
            timer_irq  <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                // Sticky status where clear wins over fire
                if (int_clear[i]) begin
                    int_status[i] <= 1'b0;
                end else if (fire[i]) begin
                    int_status[i] <= 1'b1;
                end

                // Line masked by int_enable and dropped together with status
                if (int_clear[i]) begin
                    timer_irq[i] <= 1'b0;
                end else if (fire[i] && timer_cfg[i].int_enable) begin
                    timer_irq[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hpet_top.sv ====
// Event timer top level: register file wired to timer core
`timescale 1ns/10ps
`include "hpet_config.svh"

module hpet_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // Register port, strobe write and combinational read
    input  logic                        reg_wr,
    input  logic [`HPET_ADDR_W-1:0]     reg_addr,
    input  logic [31:0]                 reg_wdata,
    output logic [31:0]                 reg_rdata,

    // Interrupts
    output logic [`HPET_NUM_TIMERS-1:0] timer_irq,
    output logic [`HPET_NUM_TIMERS-1:0] int_status
);

    import hpet_pkg::*;

    // Register file to core
    logic                        hpet_enable;
    hpet_timer_cfg_t             timer_cfg [`HPET_NUM_TIMERS];
    logic                        counter_write;
    logic [63:0]                 counter_wdata;
    hpet_comp_wr_t               comp_wr;
    logic [`HPET_NUM_TIMERS-1:0] int_clear;

    // Core readback
    logic [63:0]                 counter_rdata;
    logic [63:0]                 comp_rdata [`HPET_NUM_TIMERS];

    hpet_regs regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .counter_rdata (counter_rdata),
        .comp_rdata    (comp_rdata),
        .int_status    (int_status),
        .hpet_enable   (hpet_enable),
        .timer_cfg     (timer_cfg),
        .counter_write (counter_write),
        .counter_wdata (counter_wdata),
        .comp_wr       (comp_wr),
        .int_clear     (int_clear)
    );

    hpet_core core_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .hpet_enable   (hpet_enable),
        .timer_cfg     (timer_cfg),
        .counter_write (counter_write),
        .counter_wdata (counter_wdata),
        .comp_wr       (comp_wr),
        .int_clear     (int_clear),
        .counter_rdata (counter_rdata),
        .comp_rdata    (comp_rdata),
        .int_status    (int_status),
        .timer_irq     (timer_irq)
    );

endmodule

// ==== tb_hpet.sv ====
// Event timer testbench: clock, reset, register tasks, LCG stimulus, assertion checks
`timescale 1ns/10ps
`include "hpet_config.svh"

module tb_hpet;

    localparam int N        = `HPET_NUM_TIMERS;
    localparam int AW       = `HPET_ADDR_W;
    localparam int WAIT_MAX = 2000;

    // Global register words
    localparam logic [AW-1:0] ADDR_GEN    = AW'(0);
    localparam logic [AW-1:0] ADDR_STATUS = AW'(1);
    localparam logic [AW-1:0] ADDR_CNT_LO = AW'(2);
    localparam logic [AW-1:0] ADDR_CNT_HI = AW'(3);

    // Word offsets inside a timer block
    localparam int OFF_CFG = 0;
    localparam int OFF_LO  = 1;
    localparam int OFF_HI  = 2;

    // TMR_CONFIG bits
    localparam logic [31:0] CFG_EN   = 32'h1;
    localparam logic [31:0] CFG_INT  = 32'h2;
    localparam logic [31:0] CFG_PER  = 32'h4;
    localparam logic [31:0] CFG_FULL = 32'h8;

    logic          clk;
    logic          rst_n;
    logic          reg_wr;
    logic [AW-1:0] reg_addr;
    logic [31:0]   reg_wdata;
    logic [31:0]   reg_rdata;
    logic [N-1:0]  timer_irq;
    logic [N-1:0]  int_status;

    int unsigned checks;
    int unsigned errors;
    int unsigned assert_errors;
    int unsigned timeouts;
    logic [31:0] lcg_state;

    hpet_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .timer_irq  (timer_irq),
        .int_status (int_status)
    );

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    // An irq line is never up without its status bit
    irq_needs_status: assert property (@(posedge clk) disable iff (!rst_n)
        ((timer_irq & ~int_status) == '0))
    else begin
        assert_errors++;
        $display("error t=%0t signal timer_irq expected %0h actual %0h",
                 $time, timer_irq & int_status, timer_irq);
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random span in 20..200
    task automatic rand_span(output logic [31:0] v);
        lcg_state = lcg_next(lcg_state);
        v = 32'd20 + (lcg_state >> 8) % 32'd181;
    endtask

    function automatic logic [AW-1:0] tmr_addr(input int t, input int off);
        return AW'(`HPET_TMR_BASE + `HPET_TMR_STRIDE * t + off);
    endfunction

    // Write strobe held for one edge
    task automatic reg_write(input logic [AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr    = 1'b0;
    endtask

    // Combinational read sampled mid-cycle
    task automatic reg_read(input logic [AW-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        reg_addr = addr;
        #1;
        data = reg_rdata;
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("error t=%0t signal %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic wait_status(input int idx, input string what);
        int n;
        n = 0;
        while (int_status[idx] !== 1'b1 && n < WAIT_MAX) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (int_status[idx] !== 1'b1) begin
            timeouts++;
            $display("Timed out waiting for %s", what);
        end
    endtask

    // LO first so the HI write keeps a small live low half
    task automatic load_counter_zero();
        reg_write(ADDR_CNT_LO, 32'h0);
        reg_write(ADDR_CNT_HI, 32'h0);
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [31:0] val_lo;
        logic [31:0] val_hi;
        logic [31:0] span;
        logic [31:0] comp;
        int          k;

        checks        = 0;
        errors        = 0;
        assert_errors = 0;
        timeouts      = 0;
        lcg_state     = 32'ha93006b4;
        rst_n         = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values across the whole map
        for (int a = 0; a < 4; a++) begin
            reg_read(AW'(a), rd);
            check_eq($sformatf("reg_rdata[%0d]", a), 64'd0, 64'(rd));
        end
        for (int t = 0; t < N; t++) begin
            for (int o = 0; o < 3; o++) begin
                reg_read(tmr_addr(t, o), rd);
                check_eq($sformatf("timer%0d word %0d", t, o), 64'd0, 64'(rd));
            end
        end
        check_eq("timer_irq", 64'd0, 64'(timer_irq));

        // Counter frozen while disabled
        reg_read(ADDR_CNT_LO, rd);
        repeat (5) @(posedge clk);
        reg_read(ADDR_CNT_LO, rd2);
        check_eq("counter_lo held", 64'(rd), 64'(rd2));

        // Half writes read back exactly
        lcg_state = lcg_next(lcg_state);
        val_lo    = lcg_state;
        lcg_state = lcg_next(lcg_state);
        val_hi    = lcg_state;
        reg_write(ADDR_CNT_LO, val_lo);
        reg_write(ADDR_CNT_HI, val_hi);
        reg_read(ADDR_CNT_LO, rd);
        check_eq("counter_lo", 64'(val_lo), 64'(rd));
        reg_read(ADDR_CNT_HI, rd);
        check_eq("counter_hi", 64'(val_hi), 64'(rd));

        // Second counter read lands one edge later than the gap
        reg_write(ADDR_GEN, 32'h1);
        reg_read(ADDR_GEN, rd);
        check_eq("gen_config", 64'd1, 64'(rd));
        rand_span(span);
        reg_read(ADDR_CNT_LO, rd);
        repeat (span) @(posedge clk);
        reg_read(ADDR_CNT_LO, rd2);
        check_eq("counter_lo delta", 64'(span + 32'd1), 64'(rd2 - rd));

        // One-shot timer 0 with irq
        load_counter_zero();
        reg_read(ADDR_CNT_LO, rd);
        rand_span(span);
        comp = rd + span;
        reg_write(tmr_addr(0, OFF_HI), 32'h0);
        reg_write(tmr_addr(0, OFF_LO), comp);
        reg_write(tmr_addr(0, OFF_CFG), CFG_EN | CFG_INT);
        // Counter stays on the read port while waiting
        reg_addr = ADDR_CNT_LO;
        wait_status(0, "one-shot fire on timer 0");
        // Status rises at the edge that moves the counter one past the comparator
        check_eq("counter_lo at status rise", 64'(comp + 32'd1), 64'(reg_rdata));
        check_eq("timer_irq[0]", 64'd1, 64'(timer_irq[0]));
        for (k = 0; k < 50; k++) begin
            @(posedge clk);
            #2;
            check_eq("int_status[0]", 64'd1, 64'(int_status[0]));
            check_eq("timer_irq[0]", 64'd1, 64'(timer_irq[0]));
        end
        reg_read(tmr_addr(0, OFF_LO), rd);
        check_eq("comparator[0]", 64'(comp), 64'(rd));

        // Masked timer 1
        reg_read(ADDR_CNT_LO, rd);
        rand_span(span);
        reg_write(tmr_addr(1, OFF_HI), 32'h0);
        reg_write(tmr_addr(1, OFF_LO), rd + span);
        reg_write(tmr_addr(1, OFF_CFG), CFG_EN);
        wait_status(1, "masked fire on timer 1");
        check_eq("timer_irq[1]", 64'd0, 64'(timer_irq[1]));

        // Write-one-to-clear per bit
        reg_write(ADDR_STATUS, 32'h1);
        check_eq("int_status[0]", 64'd0, 64'(int_status[0]));
        check_eq("timer_irq[0]", 64'd0, 64'(timer_irq[0]));
        check_eq("int_status[1]", 64'd1, 64'(int_status[1]));
        reg_write(ADDR_STATUS, 32'h2);
        reg_read(ADDR_STATUS, rd);
        check_eq("int_status reg", 64'd0, 64'(rd));
        reg_write(tmr_addr(0, OFF_CFG), 32'h0);
        reg_write(tmr_addr(1, OFF_CFG), 32'h0);

        // Periodic timer 2 steps its comparator by the period
        load_counter_zero();
        rand_span(span);
        comp = span;
        reg_write(tmr_addr(2, OFF_HI), 32'h0);
        reg_write(tmr_addr(2, OFF_LO), span);
        reg_write(tmr_addr(2, OFF_CFG), CFG_EN | CFG_INT | CFG_PER);
        for (k = 0; k < 3; k++) begin
            wait_status(2, "periodic fire on timer 2");
            check_eq("timer_irq[2]", 64'd1, 64'(timer_irq[2]));
            comp = comp + span;
            reg_read(tmr_addr(2, OFF_LO), rd);
            check_eq("comparator[2]", 64'(comp), 64'(rd));
            reg_write(ADDR_STATUS, 32'h4);
        end
        reg_write(tmr_addr(2, OFF_CFG), 32'h0);
        reg_write(ADDR_STATUS, 32'h4);

        // Low-half compare ignores COMP_HI
        load_counter_zero();
        reg_read(ADDR_CNT_LO, rd);
        rand_span(span);
        comp = rd + span;
        reg_write(tmr_addr(1, OFF_HI), 32'h1);
        reg_write(tmr_addr(1, OFF_LO), comp);
        reg_write(tmr_addr(1, OFF_CFG), CFG_EN);
        reg_addr = ADDR_CNT_LO;
        wait_status(1, "32-bit compare fire on timer 1");
        check_eq("counter_lo at status rise", 64'(comp + 32'd1), 64'(reg_rdata));
        reg_write(tmr_addr(1, OFF_CFG), 32'h0);
        reg_write(ADDR_STATUS, 32'h2);

        // Full width keeps the same value out of reach
        load_counter_zero();
        reg_write(tmr_addr(1, OFF_CFG), CFG_EN | CFG_FULL);
        rd = 32'h0;
        k  = 0;
        while (rd <= comp + 32'd10 && k < WAIT_MAX) begin
            reg_read(ADDR_CNT_LO, rd);
            k++;
        end
        if (rd <= comp + 32'd10) begin
            timeouts++;
            $display("Timed out waiting for the counter to pass the low comparator half");
        end
        check_eq("int_status[1]", 64'd0, 64'(int_status[1]));

        $display("checks %0d, check errors %0d, assertion errors %0d, timeouts %0d",
                 checks, errors, assert_errors, timeouts);
        if (errors == 0 && assert_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
hpet_pkg.sv
hpet_comparator.sv
hpet_regs.sv
hpet_core.sv
hpet_top.sv
tb_hpet.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_hpet -o sim_hpet
out=$(./obj_dir/sim_hpet)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
